//--- src/smu_ctl_pkg.sv
// shared types and constants for the smu control bank
// command and register structs, register address map and preset values
`default_nettype none

package smu_ctl_pkg;

  //////////////////////////////////////////////////////////////////////
  // basic types

  // one control register
  typedef logic [3:0] nib_t;
  typedef logic [7:0] addr_t;

  // one decoded write frame with the address in the high byte
  typedef struct packed {
    addr_t      addr;
    logic [7:0] value;    // low nibble set mask and high nibble clear mask
  } ctl_cmd_t;

  // whole register bank, first field in the msbs
  typedef struct packed {
    nib_t led;
    nib_t mux;
    nib_t dac;
    nib_t rails;
    nib_t dac_ref_mux;
    nib_t adc;
    nib_t mux_pol;
    nib_t mux_sel;
    nib_t relay_com;
    nib_t irange_x_sw;
    nib_t rails_oe;
    nib_t ina_vfb_sw;
    nib_t ina_ifb_sw;
    nib_t ina_vfb_atten_sw;
    nib_t isense_mux;
    nib_t relay_out;
    nib_t irange_yz_sw;
  } ctl_regs_t;

  //////////////////////////////////////////////////////////////////////
  // address map

  localparam addr_t ADDR_LED              = 8'd7;
  localparam addr_t ADDR_MUX              = 8'd8;
  localparam addr_t ADDR_DAC              = 8'd9;
  localparam addr_t ADDR_RAILS            = 8'd10;
  localparam addr_t ADDR_DAC_REF_MUX      = 8'd12;
  localparam addr_t ADDR_ADC              = 8'd14;
  localparam addr_t ADDR_MUX_POL          = 8'd15;
  localparam addr_t ADDR_MUX_SEL          = 8'd16;
  localparam addr_t ADDR_RELAY_COM        = 8'd17;
  localparam addr_t ADDR_IRANGE_X_SW      = 8'd18;
  localparam addr_t ADDR_RAILS_OE         = 8'd24;
  localparam addr_t ADDR_INA_VFB_SW       = 8'd25;
  localparam addr_t ADDR_INA_IFB_SW       = 8'd28;
  localparam addr_t ADDR_INA_VFB_ATTEN_SW = 8'd29;
  localparam addr_t ADDR_ISENSE_MUX       = 8'd30;
  localparam addr_t ADDR_RELAY_OUT        = 8'd31;
  localparam addr_t ADDR_IRANGE_YZ_SW     = 8'd33;

  // preset commands
  localparam addr_t ADDR_SOFT_RESET = 8'd11;
  localparam addr_t ADDR_POWER_UP   = 8'd6;

  localparam int FRAME_BITS = 16;
  localparam int NUM_PERIPH = 4;

  //////////////////////////////////////////////////////////////////////
  // presets

  // safe state, rails off and dg444 switches open (active low)
  localparam ctl_regs_t CTL_DEFAULTS = '{
    led:              4'b0000,
    mux:              4'b0000,
    dac:              4'b0000,
    rails:            4'b0000,
    dac_ref_mux:      4'b0000,
    adc:              4'b0000,
    mux_pol:          4'b1111,
    mux_sel:          4'b1111,
    relay_com:        4'b0000,
    irange_x_sw:      4'b0000,
    rails_oe:         4'b0001,
    ina_vfb_sw:       4'b0000,
    ina_ifb_sw:       4'b1111,
    ina_vfb_atten_sw: 4'b0011,
    isense_mux:       4'b1111,
    relay_out:        4'b0000,
    irange_yz_sw:     4'b0000
  };

  // rails-on values for the power-up preset
  localparam nib_t PWR_RAILS       = 4'b0011;   // +5v and +-15v
  localparam nib_t PWR_DAC_REF_MUX = 4'b0011;
  localparam nib_t PWR_RAILS_OE    = 4'b0000;   // active low, outputs on
  localparam nib_t PWR_INA_VFB_SW  = 4'b1111;

endpackage

`default_nettype wire

//--- src/spi_frame_rx.sv
// spi frame receiver
// pin synchronizer and edge detect, 16 bit shift register and bit counter
// credit counter that gates pushes into the command queue
`default_nettype none

module spi_frame_rx #(
  parameter int DEPTH = 4
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  sclk,
  input  logic                  cs_n,
  input  logic                  mosi,
  input  logic                  credit_ret,
  output logic                  push,
  output smu_ctl_pkg::ctl_cmd_t push_cmd,
  output logic                  frame_dropped
);

  import smu_ctl_pkg::*;

  localparam int CW    = $clog2(DEPTH + 1);
  localparam int CNT_W = $clog2(FRAME_BITS) + 1;

  // the three spi pins move through the synchronizer together
  typedef struct packed {
    logic sclk;
    logic cs_n;
    logic mosi;
  } spi_pins_t;

  localparam spi_pins_t PINS_IDLE = '{sclk: 1'b0, cs_n: 1'b1, mosi: 1'b0};

  spi_pins_t pins_meta;
  spi_pins_t pins_sync;
  logic      sclk_prev;
  logic      cs_n_prev;

  logic [FRAME_BITS-1:0] shift_q;
  logic [CNT_W-1:0]      bit_cnt;
  logic [CW-1:0]         credits;

  logic sclk_rise;
  logic cs_rise;
  logic frame_ok;
  logic has_credit;

  //////////////////////////////////////////////////////////////////////
  // pin synchronizer and edge detect

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      pins_meta <= PINS_IDLE;
      pins_sync <= PINS_IDLE;
      sclk_prev <= 1'b0;
      cs_n_prev <= 1'b1;
    end
    else
    begin
      pins_meta <= '{sclk: sclk, cs_n: cs_n, mosi: mosi};
      pins_sync <= pins_meta;
      sclk_prev <= pins_sync.sclk;
      cs_n_prev <= pins_sync.cs_n;
    end
  end

  // sclk edges only count while selected
  assign sclk_rise = pins_sync.sclk & ~sclk_prev & ~pins_sync.cs_n;
  assign cs_rise   = pins_sync.cs_n & ~cs_n_prev;

  //////////////////////////////////////////////////////////////////////
  // shift register and bit count

  // msb first, so shift toward the msb
  always_ff @(posedge clk)
  begin
    if (sclk_rise)
      shift_q <= {shift_q[FRAME_BITS-2:0], pins_sync.mosi};
  end

  // saturates so that long frames never wrap back to 16
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      bit_cnt <= '0;
    else if (pins_sync.cs_n)
      bit_cnt <= '0;
    else if (sclk_rise && bit_cnt != '1)
      bit_cnt <= bit_cnt + 1'b1;
  end

  // only exact 16 bit frames are commands
  assign frame_ok = cs_rise && (bit_cnt == CNT_W'(FRAME_BITS));

  // a push already in flight holds one credit that is not yet spent
  assign has_credit = credits > CW'(push);

  //////////////////////////////////////////////////////////////////////
  // push and credits

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      push          <= 1'b0;
      frame_dropped <= 1'b0;
    end
    else
    begin
      push <= frame_ok && has_credit;
      // sticky until rst_n
      if (frame_ok && !has_credit)
        frame_dropped <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (frame_ok)
      push_cmd <= ctl_cmd_t'(shift_q);
  end

  // spend on push, earn back on each fifo pop
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      credits <= CW'(DEPTH);
    else
    begin
      case ({push, credit_ret})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/cmd_fifo.sv
// command fifo between the frame receiver and the register file
// circular buffer with read and write pointers and a fill count
// one credit goes back to the receiver per pop
`default_nettype none

module cmd_fifo #(
  parameter int DEPTH = 4
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  push,
  input  smu_ctl_pkg::ctl_cmd_t push_cmd,
  input  logic                  pop,
  output logic                  valid,
  output smu_ctl_pkg::ctl_cmd_t pop_cmd,
  output logic                  credit_ret
);

  import smu_ctl_pkg::*;

  // pointer width, at least one bit for a depth of one
  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  ctl_cmd_t mem [DEPTH];

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          pop_ok;

  // no full check here, the sender never pushes without a credit
  assign valid      = count != '0;
  assign pop_ok     = pop && valid;
  assign credit_ret = pop_ok;
  assign pop_cmd    = mem[rd_ptr];

  // storage
  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= push_cmd;
  end

  // pointers wrap at DEPTH, which need not be a power of two
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop_ok)
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
    end
  end

  // fill level
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      count <= '0;
    else
    begin
      case ({push, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/ctl_reg_file.sv
// control register file
// set/clear/toggle update, soft reset and power-up presets
// chip-select mux for the downstream peripherals
`default_nettype none

module ctl_reg_file (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                valid,
  input  smu_ctl_pkg::ctl_cmd_t               pop_cmd,
  input  logic                                cs2_n,
  output logic                                pop,
  output smu_ctl_pkg::ctl_regs_t              regs,
  output logic [smu_ctl_pkg::NUM_PERIPH-1:0]  periph_cs_n
);

  import smu_ctl_pkg::*;

  ctl_regs_t regs_next;
  logic      cs2_meta;
  logic      cs2_sync;

  // low nibble sets and high nibble clears
  // overlap means toggle those bits and keep the rest
  function automatic nib_t apply_update(nib_t cur, logic [7:0] value);
    nib_t set_m;
    nib_t clr_m;
    nib_t both;
    set_m = value[3:0];
    clr_m = value[7:4];
    both  = set_m & clr_m;
    if (both != '0)
      return cur ^ both;
    else
      return (cur | set_m) & ~clr_m;
  endfunction

  // never stalls, take every command as it shows up
  assign pop = valid;

  //////////////////////////////////////////////////////////////////////
  // command decode

  always_comb
  begin
    regs_next = regs;
    case (pop_cmd.addr)
      ADDR_LED:         regs_next.led = apply_update(regs.led, pop_cmd.value);
      ADDR_MUX:         regs_next.mux = apply_update(regs.mux, pop_cmd.value);
      ADDR_DAC:         regs_next.dac = apply_update(regs.dac, pop_cmd.value);
      ADDR_RAILS:       regs_next.rails = apply_update(regs.rails, pop_cmd.value);
      ADDR_DAC_REF_MUX:
        regs_next.dac_ref_mux = apply_update(regs.dac_ref_mux, pop_cmd.value);
      ADDR_ADC:         regs_next.adc = apply_update(regs.adc, pop_cmd.value);
      ADDR_MUX_POL:     regs_next.mux_pol = apply_update(regs.mux_pol, pop_cmd.value);
      ADDR_MUX_SEL:     regs_next.mux_sel = apply_update(regs.mux_sel, pop_cmd.value);
      ADDR_RELAY_COM:
        regs_next.relay_com = apply_update(regs.relay_com, pop_cmd.value);
      ADDR_IRANGE_X_SW:
        regs_next.irange_x_sw = apply_update(regs.irange_x_sw, pop_cmd.value);
      ADDR_RAILS_OE:
        regs_next.rails_oe = apply_update(regs.rails_oe, pop_cmd.value);
      ADDR_INA_VFB_SW:
        regs_next.ina_vfb_sw = apply_update(regs.ina_vfb_sw, pop_cmd.value);
      ADDR_INA_IFB_SW:
        regs_next.ina_ifb_sw = apply_update(regs.ina_ifb_sw, pop_cmd.value);
      ADDR_INA_VFB_ATTEN_SW:
        regs_next.ina_vfb_atten_sw = apply_update(regs.ina_vfb_atten_sw, pop_cmd.value);
      ADDR_ISENSE_MUX:
        regs_next.isense_mux = apply_update(regs.isense_mux, pop_cmd.value);
      ADDR_RELAY_OUT:
        regs_next.relay_out = apply_update(regs.relay_out, pop_cmd.value);
      ADDR_IRANGE_YZ_SW:
        regs_next.irange_yz_sw = apply_update(regs.irange_yz_sw, pop_cmd.value);

      // soft reset, same state as rst_n
      ADDR_SOFT_RESET:  regs_next = CTL_DEFAULTS;

      // power-up, expects the dac already configured before the rails come on
      ADDR_POWER_UP:
      begin
        regs_next             = CTL_DEFAULTS;
        regs_next.mux         = regs.mux;
        regs_next.dac         = regs.dac;
        regs_next.rails       = PWR_RAILS;
        regs_next.dac_ref_mux = PWR_DAC_REF_MUX;
        regs_next.rails_oe    = PWR_RAILS_OE;
        regs_next.ina_vfb_sw  = PWR_INA_VFB_SW;
      end

      // unused address, nothing changes
      default:          regs_next = regs;
    endcase
  end

  // registers take the decoded value the cycle after the pop
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      regs <= CTL_DEFAULTS;
    else if (pop)
      regs <= regs_next;
  end

  //////////////////////////////////////////////////////////////////////
  // chip-select mux

  // cs2_n is asynchronous to clk
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      cs2_meta <= 1'b1;
      cs2_sync <= 1'b1;
    end
    else
    begin
      cs2_meta <= cs2_n;
      cs2_sync <= cs2_meta;
    end
  end

  // selected peripherals go low only while cs2 is asserted
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      periph_cs_n <= '1;
    else if (cs2_sync)
      periph_cs_n <= '1;
    else
      periph_cs_n <= ~regs.mux[NUM_PERIPH-1:0];
  end

endmodule

`default_nettype wire

//--- src/smu_ctl_top.sv
// smu control bank top level
// spi frame receiver, command fifo and register file
`default_nettype none

module smu_ctl_top #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                sclk,
  input  logic                                cs_n,
  input  logic                                mosi,
  input  logic                                cs2_n,
  output smu_ctl_pkg::ctl_regs_t              regs,
  output logic [smu_ctl_pkg::NUM_PERIPH-1:0]  periph_cs_n,
  output logic                                frame_dropped
);

  import smu_ctl_pkg::*;

  // receiver to fifo
  logic     push;
  ctl_cmd_t push_cmd;
  logic     credit_ret;

  // fifo to register file
  logic     valid;
  ctl_cmd_t pop_cmd;
  logic     pop;

  // credits start at the fifo depth
  spi_frame_rx #(
    .DEPTH (FIFO_DEPTH)
  ) u_rx (
    .clk           (clk),
    .rst_n         (rst_n),
    .sclk          (sclk),
    .cs_n          (cs_n),
    .mosi          (mosi),
    .credit_ret    (credit_ret),
    .push          (push),
    .push_cmd      (push_cmd),
    .frame_dropped (frame_dropped)
  );

  cmd_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .push       (push),
    .push_cmd   (push_cmd),
    .pop        (pop),
    .valid      (valid),
    .pop_cmd    (pop_cmd),
    .credit_ret (credit_ret)
  );

  ctl_reg_file u_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .valid       (valid),
    .pop_cmd     (pop_cmd),
    .cs2_n       (cs2_n),
    .pop         (pop),
    .regs        (regs),
    .periph_cs_n (periph_cs_n)
  );

endmodule

`default_nettype wire

//--- test/smu_ctl_properties.sv
// concurrent assertions on the credit loop and the command fifo
// bound into the smu control top level
`default_nettype none

module smu_ctl_properties #(
  parameter int DEPTH = 4
) (
  input logic                         clk,
  input logic                         rst_n,
  input logic                         push,
  input logic [$clog2(DEPTH + 1)-1:0] credits,
  input logic                         pop,
  input logic                         valid,
  input logic                         frame_dropped
);

  localparam int CW = $clog2(DEPTH + 1);

  //////////////////////////////////////////////////////////////////////
  // credit loop

  credits_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    credits <= CW'(DEPTH))
    else $error("credit count above the fifo depth");

  push_has_credit: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> credits != '0)
    else $error("push while no credits left");

  // fifo side
  pop_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
    pop |-> valid)
    else $error("pop from an empty fifo");

  dropped_clear_after_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> !frame_dropped)
    else $error("frame_dropped set right after reset");

endmodule

bind smu_ctl_top smu_ctl_properties #(
  .DEPTH (FIFO_DEPTH)
) u_props (
  .clk           (clk),
  .rst_n         (rst_n),
  .push          (push),
  .credits       (u_rx.credits),
  .pop           (pop),
  .valid         (valid),
  .frame_dropped (frame_dropped)
);

`default_nettype wire

//--- test/tb_smu_ctl.sv
// testbench for the smu control bank
// clock and reset, spi frame driver, stimulus table and reference model
// compare tasks for the register bank, the chip selects and the drop flag
`default_nettype none

module tb_smu_ctl;

  import smu_ctl_pkg::*;

  localparam int FIFO_DEPTH     = 4;
  localparam int HALF_SCLK      = 4;     // clk cycles per sclk half period
  localparam int UPDATE_TIMEOUT = 200;
  localparam int CS_TIMEOUT     = 20;
  localparam int DRAIN_CYCLES   = 8;     // worst case latency with an empty fifo

  // one stimulus row
  typedef struct {
    int         bits;
    addr_t      addr;
    logic [7:0] value;
    logic       cs2_low;
  } row_t;

  logic                  clk;
  logic                  rst_n;
  logic                  sclk;
  logic                  cs_n;
  logic                  mosi;
  logic                  cs2_n;
  ctl_regs_t             regs;
  logic [NUM_PERIPH-1:0] periph_cs_n;
  logic                  frame_dropped;

  row_t      rows[$];
  ctl_regs_t model;
  int        err_count;
  int        timeout_count;

  smu_ctl_top #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) DUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .sclk          (sclk),
    .cs_n          (cs_n),
    .mosi          (mosi),
    .cs2_n         (cs2_n),
    .regs          (regs),
    .periph_cs_n   (periph_cs_n),
    .frame_dropped (frame_dropped)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // reference model

  // reset state from the register map
  function automatic ctl_regs_t expected_defaults();
    ctl_regs_t d;
    d                  = '0;
    d.mux_pol          = 4'b1111;
    d.mux_sel          = 4'b1111;
    d.ina_ifb_sw       = 4'b1111;
    d.isense_mux       = 4'b1111;
    d.ina_vfb_atten_sw = 4'b0011;
    d.rails_oe         = 4'b0001;
    return d;
  endfunction

  // bit by bit, overlap toggles, otherwise set then clear
  function automatic nib_t expect_nibble(nib_t cur, logic [7:0] value);
    nib_t s;
    nib_t c;
    nib_t res;
    logic overlap;
    s       = value[3:0];
    c       = value[7:4];
    overlap = |(s & c);
    res     = cur;
    for (int i = 0; i < 4; i++)
    begin
      if (overlap)
        res[i] = (s[i] && c[i]) ? ~cur[i] : cur[i];
      else if (c[i])
        res[i] = 1'b0;
      else if (s[i])
        res[i] = 1'b1;
    end
    return res;
  endfunction

  function automatic ctl_regs_t model_write(ctl_regs_t m, addr_t addr, logic [7:0] value);
    ctl_regs_t n;
    n = m;
    case (addr)
      ADDR_LED:              n.led = expect_nibble(m.led, value);
      ADDR_MUX:              n.mux = expect_nibble(m.mux, value);
      ADDR_DAC:              n.dac = expect_nibble(m.dac, value);
      ADDR_RAILS:            n.rails = expect_nibble(m.rails, value);
      ADDR_DAC_REF_MUX:      n.dac_ref_mux = expect_nibble(m.dac_ref_mux, value);
      ADDR_ADC:              n.adc = expect_nibble(m.adc, value);
      ADDR_MUX_POL:          n.mux_pol = expect_nibble(m.mux_pol, value);
      ADDR_MUX_SEL:          n.mux_sel = expect_nibble(m.mux_sel, value);
      ADDR_RELAY_COM:        n.relay_com = expect_nibble(m.relay_com, value);
      ADDR_IRANGE_X_SW:      n.irange_x_sw = expect_nibble(m.irange_x_sw, value);
      ADDR_RAILS_OE:         n.rails_oe = expect_nibble(m.rails_oe, value);
      ADDR_INA_VFB_SW:       n.ina_vfb_sw = expect_nibble(m.ina_vfb_sw, value);
      ADDR_INA_IFB_SW:       n.ina_ifb_sw = expect_nibble(m.ina_ifb_sw, value);
      ADDR_INA_VFB_ATTEN_SW: n.ina_vfb_atten_sw = expect_nibble(m.ina_vfb_atten_sw, value);
      ADDR_ISENSE_MUX:       n.isense_mux = expect_nibble(m.isense_mux, value);
      ADDR_RELAY_OUT:        n.relay_out = expect_nibble(m.relay_out, value);
      ADDR_IRANGE_YZ_SW:     n.irange_yz_sw = expect_nibble(m.irange_yz_sw, value);
      ADDR_SOFT_RESET:       n = expected_defaults();
      // rails on while mux and dac survive
      ADDR_POWER_UP:
      begin
        n             = expected_defaults();
        n.led         = 4'b0000;
        n.mux         = m.mux;
        n.dac         = m.dac;
        n.rails       = 4'b0011;
        n.dac_ref_mux = 4'b0011;
        n.rails_oe    = 4'b0000;
        n.ina_vfb_sw  = 4'b1111;
      end
      default:               n = m;
    endcase
    return n;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // compare tasks

  task automatic check_regs(ctl_regs_t got, ctl_regs_t exp, string what);
    if (got !== exp)
    begin
      err_count++;
      $display("[ERROR] %0t %s: regs %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_cs(logic [NUM_PERIPH-1:0] got, logic [NUM_PERIPH-1:0] exp,
                          string what);
    if (got !== exp)
    begin
      err_count++;
      $display("[ERROR] %0t %s: periph_cs_n %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(logic got, logic exp, string what);
    if (got !== exp)
    begin
      err_count++;
      $display("[ERROR] %0t %s: frame_dropped %b, expected %b", $time, what, got, exp);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // spi driver and waits

  // msb first with mosi set a half period before each sclk rise
  task automatic send_frame(int nbits, logic [15:0] frame);
    logic [15:0] sh;
    sh = frame;
    @(posedge clk);
    cs_n <= 1'b0;
    repeat (HALF_SCLK) @(posedge clk);
    for (int j = 0; j < nbits; j++)
    begin
      mosi <= sh[15];
      sh = {sh[14:0], 1'b0};
      repeat (HALF_SCLK) @(posedge clk);
      sclk <= 1'b1;
      repeat (HALF_SCLK) @(posedge clk);
      sclk <= 1'b0;
    end
    repeat (HALF_SCLK) @(posedge clk);
    cs_n <= 1'b1;
    mosi <= 1'b0;
  endtask

  task automatic wait_regs(int row);
    int n;
    for (n = 0; n < UPDATE_TIMEOUT; n++)
    begin
      @(negedge clk);
      if (regs === model)
        break;
    end
    if (n == UPDATE_TIMEOUT)
    begin
      timeout_count++;
      $display("row %0d: the register bank did not update within %0d cycles",
               row, UPDATE_TIMEOUT);
    end
    // a late or unwanted change still shows up here
    repeat (DRAIN_CYCLES) @(negedge clk);
    check_regs(regs, model, $sformatf("row %0d", row));
  endtask

  task automatic wait_cs(logic [NUM_PERIPH-1:0] exp, int row);
    int n;
    for (n = 0; n < CS_TIMEOUT; n++)
    begin
      @(negedge clk);
      if (periph_cs_n === exp)
        break;
    end
    if (n == CS_TIMEOUT)
    begin
      timeout_count++;
      $display("row %0d: the chip selects did not settle within %0d cycles",
               row, CS_TIMEOUT);
    end
    check_cs(periph_cs_n, exp, $sformatf("row %0d", row));
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus table

  task automatic add_row(int bits, addr_t addr, logic [7:0] value, logic cs2_low);
    row_t r;
    r.bits    = bits;
    r.addr    = addr;
    r.value   = value;
    r.cs2_low = cs2_low;
    rows.push_back(r);
  endtask

  task automatic build_table();
    nib_t s;
    nib_t c;
    // plain set and clear
    add_row(16, ADDR_LED, 8'h05, 1'b0);
    add_row(16, ADDR_LED, 8'h41, 1'b0);
    add_row(16, ADDR_DAC, 8'h0F, 1'b0);
    add_row(16, ADDR_RAILS_OE, 8'h16, 1'b0);
    // random disjoint masks
    s = 4'($urandom);
    c = 4'($urandom) & ~s;
    add_row(16, ADDR_ADC, {c, s}, 1'b0);
    s = 4'($urandom);
    c = 4'($urandom) & ~s;
    add_row(16, ADDR_RELAY_COM, {c, s}, 1'b0);
    s = 4'($urandom);
    c = 4'($urandom) & ~s;
    add_row(16, ADDR_IRANGE_YZ_SW, {c, s}, 1'b0);
    // overlapping masks toggle
    add_row(16, ADDR_DAC, 8'h33, 1'b0);
    add_row(16, ADDR_MUX_POL, 8'h35, 1'b0);
    s = 4'($urandom) | 4'b0001;
    c = 4'($urandom) | 4'b0001;
    add_row(16, ADDR_ISENSE_MUX, {c, s}, 1'b0);
    // presets
    add_row(16, ADDR_MUX, 8'h02, 1'b1);
    add_row(16, ADDR_POWER_UP, 8'h00, 1'b0);
    add_row(16, ADDR_SOFT_RESET, 8'h00, 1'b0);
    // bad lengths and an unused address
    // shifted by one bit, each bad length frame would write led or adc
    add_row(15, ADDR_ADC, 8'h1E, 1'b0);
    add_row(17, ADDR_LED, 8'h0F, 1'b0);
    add_row(16, 8'd40, 8'h0F, 1'b0);
    // chip-select mux
    add_row(16, ADDR_MUX, 8'hA5, 1'b1);
    add_row(16, 8'd40, 8'h00, 1'b0);
  endtask

  initial
  begin
    row_t                  r;
    int unsigned           seed;
    logic [NUM_PERIPH-1:0] exp_cs;
    seed          = $urandom(23);
    err_count     = 0;
    timeout_count = 0;
    rst_n         = 1'b0;
    sclk          = 1'b0;
    cs_n          = 1'b1;
    mosi          = 1'b0;
    cs2_n         = 1'b1;
    build_table();

    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    model = expected_defaults();
    check_regs(regs, model, "after reset");
    check_cs(periph_cs_n, '1, "after reset");
    check_flag(frame_dropped, 1'b0, "after reset");

    for (int i = 0; i < rows.size(); i++)
    begin
      r = rows[i];
      @(posedge clk);
      cs2_n <= ~r.cs2_low;
      send_frame(r.bits, {r.addr, r.value});
      // only exact length frames reach the bank
      if (r.bits == FRAME_BITS)
        model = model_write(model, r.addr, r.value);
      wait_regs(i);
      exp_cs = r.cs2_low ? ~model.mux[NUM_PERIPH-1:0] : '1;
      wait_cs(exp_cs, i);
      check_flag(frame_dropped, 1'b0, $sformatf("row %0d", i));
    end

    $display("value errors: %0d, timeouts: %0d", err_count, timeout_count);
    if (err_count == 0 && timeout_count == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- smu_ctl.f
src/smu_ctl_pkg.sv
src/spi_frame_rx.sv
src/cmd_fifo.sv
src/ctl_reg_file.sv
src/smu_ctl_top.sv
test/smu_ctl_properties.sv
test/tb_smu_ctl.sv

//--- run_sim.sh
#!/bin/sh
# build and run the smu control bank testbench with verilator
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
  --top-module tb_smu_ctl \
  -Mdir "$BUILD_DIR" \
  -f smu_ctl.f

# the log decides the result, not the exit status
if ! "./$BUILD_DIR/Vtb_smu_ctl" > "$LOG" 2>&1; then
  echo "simulation exited with a non-zero status"
fi

cat "$LOG"

if grep -q "^Finished with no errors$" "$LOG"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see $LOG"
  exit 1
fi
